// ==== include/snowball_defines.svh ====
/*
 * Widths and field positions shared by the cache, TLB and arbiter.
 * Include in any RTL file that sizes a port, a field or an array.
 */
`ifndef SNOWBALL_DEFINES_SVH
`define SNOWBALL_DEFINES_SVH

// --------------------------------------------------
// bus widths
`define SNOWBALL_ADDR_W   32   // byte address
`define SNOWBALL_DATA_W   32   // one word per line
`define SNOWBALL_PAGE_W   16   // physical and virtual page

// --------------------------------------------------
// cache and tlb fields
`define SNOWBALL_IDX_W    8    // cache index and tlb index
`define SNOWBALL_TAG_W    24   // ppage plus addr[15:8]
`define SNOWBALL_TLB_LSB  8    // tlb index starts here
`define SNOWBALL_PAGE_LSB 16   // page field starts here
`define SNOWBALL_LINES    (1 << `SNOWBALL_IDX_W)

`endif

// ==== rtl/snowball_pkg.sv ====
/*
 * Types for the snowball memory subsystem.
 * The controller FSM uses the state enum. The memory operation enum
 * travels from the controller to the arbiter and on to memory.
 */
package snowball_pkg;

  // controller FSM states
  typedef enum logic [2:0]
  {
    idle,             // waiting for a request
    lookup,           // array outputs valid, decide
    translate_fault,  // report mmu fault
    mem_wait,         // miss or write-through in flight
    respond           // hit or tlb write done
  } cache_state_e;

  // memory port operation
  typedef enum logic
  {
    op_read  = 1'b0,
    op_write = 1'b1
  } mem_op_e;

endpackage

// ==== rtl/cache_array.sv ====
/*
 * Direct-mapped cache storage: data, tag and a valid bit per line.
 * Read is registered on rd_en. The write port fills or updates a line
 * and sets it valid. The DMA snoop invalidate clears a valid bit.
 */
`timescale 1ns/100ps
`include "snowball_defines.svh"

module cache_array
(
  input  logic                        CPU_CLK,
  input  logic                        RST,
  input  logic [`SNOWBALL_IDX_W-1:0]  rd_idx,
  input  logic                        rd_en,
  input  logic                        wr_en,
  input  logic [`SNOWBALL_IDX_W-1:0]  wr_idx,
  input  logic [`SNOWBALL_TAG_W-1:0]  wr_tag,
  input  logic [`SNOWBALL_DATA_W-1:0] wr_data,
  input  logic                        inval,
  input  logic [`SNOWBALL_IDX_W-1:0]  inval_idx,
  output logic [`SNOWBALL_TAG_W-1:0]  rd_tag,
  output logic [`SNOWBALL_DATA_W-1:0] rd_data,
  output logic                        rd_valid
);

  logic [`SNOWBALL_TAG_W-1:0]  tag_mem  [0:`SNOWBALL_LINES-1];
  logic [`SNOWBALL_DATA_W-1:0] data_mem [0:`SNOWBALL_LINES-1];
  logic [`SNOWBALL_LINES-1:0]  valid;

  always_ff @(posedge CPU_CLK)
  begin
    if (wr_en)
    begin
      tag_mem[wr_idx]  <= wr_tag;
      data_mem[wr_idx] <= wr_data;
    end
    if (rd_en)
    begin
      rd_tag  <= tag_mem[rd_idx];
      rd_data <= data_mem[rd_idx];
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      valid    <= '0;
      rd_valid <= 1'b0;
    end
    else
    begin
      if (wr_en)
        valid[wr_idx] <= 1'b1;
      if (inval)
        valid[inval_idx] <= 1'b0;   // snoop wins over a fill
      if (rd_en)
        rd_valid <= valid[rd_idx];
    end
  end

endmodule

// ==== rtl/tlb_array.sv ====
/*
 * One-level TLB: physical page and virtual tag per entry, registered
 * read. With vmem high the stored page is passed out and a tag mismatch
 * raises fault. With vmem low the address passes through untranslated.
 */
`timescale 1ns/100ps
`include "snowball_defines.svh"

module tlb_array
(
  input  logic                        CPU_CLK,
  input  logic                        RST,
  input  logic [`SNOWBALL_IDX_W-1:0]  rd_idx,
  input  logic                        rd_en,
  input  logic                        wr_en,
  input  logic [`SNOWBALL_IDX_W-1:0]  wr_idx,
  input  logic [`SNOWBALL_PAGE_W-1:0] wr_ppage,
  input  logic [`SNOWBALL_PAGE_W-1:0] wr_vtag,
  input  logic [`SNOWBALL_PAGE_W-1:0] chk_vtag,
  input  logic                        vmem,
  output logic [`SNOWBALL_PAGE_W-1:0] ppage,
  output logic                        fault
);

  logic [`SNOWBALL_PAGE_W-1:0] ppage_mem [0:`SNOWBALL_LINES-1];
  logic [`SNOWBALL_PAGE_W-1:0] vtag_mem  [0:`SNOWBALL_LINES-1];
  logic [`SNOWBALL_PAGE_W-1:0] rd_ppage;
  logic [`SNOWBALL_PAGE_W-1:0] rd_vtag;
  logic                        rd_seen;

  always_ff @(posedge CPU_CLK)
  begin
    if (wr_en)
    begin
      ppage_mem[wr_idx] <= wr_ppage;
      vtag_mem[wr_idx]  <= wr_vtag;
    end
    if (rd_en)
    begin
      rd_ppage <= ppage_mem[rd_idx];
      rd_vtag  <= vtag_mem[rd_idx];
    end
  end

  // no compare before the first read after reset
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
      rd_seen <= 1'b0;
    else if (rd_en)
      rd_seen <= 1'b1;
  end

  assign ppage = vmem ? rd_ppage : chk_vtag;                  // untranslated when off
  assign fault = vmem && rd_seen && (rd_vtag != chk_vtag);

endmodule

// ==== rtl/cache_ctrl.sv ====
/*
 * CPU request engine of the write-through cache.
 * A request is captured when the FSM is idle, the arrays are read on the
 * same edge, and the lookup cycle decides between hit, fault, TLB write
 * and a memory access. Misses fill the line, writes update it, and
 * inhibited reads bypass it. A TLB write takes cpu_wdata as
 * {ppage, vtag} at the entry selected by cpu_addr[15:8].
 */
`timescale 1ns/100ps
`include "snowball_defines.svh"

module cache_ctrl
(
  input  logic                         CPU_CLK,
  input  logic                         RST,
  // cpu side
  input  logic                         cpu_en,
  input  logic                         cpu_we,
  input  logic                         tlb_we,
  input  logic [`SNOWBALL_ADDR_W-1:0]  cpu_addr,
  input  logic [`SNOWBALL_DATA_W-1:0]  cpu_wdata,
  input  logic                         vmem_en,
  input  logic                         cache_inhibit,
  output logic [`SNOWBALL_DATA_W-1:0]  cpu_rdata,
  output logic                         cpu_busy,
  output logic                         mmu_fault,
  // array reads
  output logic                         rd_en,
  output logic [`SNOWBALL_IDX_W-1:0]   rd_idx,
  output logic [`SNOWBALL_IDX_W-1:0]   tlb_rd_idx,
  input  logic [`SNOWBALL_TAG_W-1:0]   rd_tag,
  input  logic [`SNOWBALL_DATA_W-1:0]  rd_data,
  input  logic                         rd_valid,
  input  logic [`SNOWBALL_PAGE_W-1:0]  ppage,
  input  logic                         fault,
  output logic [`SNOWBALL_PAGE_W-1:0]  tlb_chk_vtag,
  output logic                         tlb_vmem,
  // array writes
  output logic                         arr_wr_en,
  output logic [`SNOWBALL_IDX_W-1:0]   arr_wr_idx,
  output logic [`SNOWBALL_TAG_W-1:0]   arr_wr_tag,
  output logic [`SNOWBALL_DATA_W-1:0]  arr_wr_data,
  output logic                         tlb_wr_en,
  output logic [`SNOWBALL_IDX_W-1:0]   tlb_wr_idx,
  output logic [`SNOWBALL_PAGE_W-1:0]  tlb_wr_ppage,
  output logic [`SNOWBALL_PAGE_W-1:0]  tlb_wr_vtag,
  // memory request
  output logic                         creq,
  output snowball_pkg::mem_op_e        cop,
  output logic [`SNOWBALL_ADDR_W-1:0]  caddr,
  output logic [`SNOWBALL_DATA_W-1:0]  cwdata,
  input  logic                         cack,
  input  logic [`SNOWBALL_DATA_W-1:0]  crdata
);

  import snowball_pkg::*;

  cache_state_e                 state;
  logic                         accept;
  logic                         hit;
  logic [`SNOWBALL_ADDR_W-1:0]  paddr;
  logic [`SNOWBALL_ADDR_W-1:0]  cyc_addr;
  logic [`SNOWBALL_DATA_W-1:0]  cyc_wdata;
  logic                         cyc_we;
  logic                         cyc_tlb;
  logic                         cyc_vmem;
  logic                         cyc_inhibit;

  // --------------------------------------------------
  // request capture and array read
  assign accept     = (cpu_en || tlb_we) && !cpu_busy && (state == idle);
  assign rd_en      = accept;
  assign rd_idx     = cpu_addr[`SNOWBALL_IDX_W-1:0];
  assign tlb_rd_idx = cpu_addr[`SNOWBALL_TLB_LSB +: `SNOWBALL_IDX_W];

  assign tlb_chk_vtag = cyc_addr[`SNOWBALL_PAGE_LSB +: `SNOWBALL_PAGE_W];
  assign tlb_vmem     = cyc_vmem;

  assign paddr = {ppage, cyc_addr[`SNOWBALL_PAGE_LSB-1:0]};   // physical address
  assign hit   = rd_valid && (rd_tag == paddr[`SNOWBALL_ADDR_W-1 -: `SNOWBALL_TAG_W]);

  // --------------------------------------------------
  // array and tlb writes
  assign arr_wr_en   = (state == mem_wait) && creq && cack && (cyc_we || !cyc_inhibit);
  assign arr_wr_idx  = cyc_addr[`SNOWBALL_IDX_W-1:0];
  assign arr_wr_tag  = paddr[`SNOWBALL_ADDR_W-1 -: `SNOWBALL_TAG_W];
  assign arr_wr_data = cyc_we ? cyc_wdata : crdata;        // update or fill

  assign tlb_wr_en    = (state == lookup) && cyc_tlb;
  assign tlb_wr_idx   = cyc_addr[`SNOWBALL_TLB_LSB +: `SNOWBALL_IDX_W];
  assign tlb_wr_ppage = cyc_wdata[`SNOWBALL_DATA_W-1 -: `SNOWBALL_PAGE_W];
  assign tlb_wr_vtag  = cyc_wdata[`SNOWBALL_PAGE_W-1:0];

  // held from creq to cack since the cycle registers only move on accept
  assign cop    = cyc_we ? op_write : op_read;
  assign caddr  = paddr;
  assign cwdata = cyc_wdata;

  // --------------------------------------------------
  // FSM
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state     <= idle;
      cpu_busy  <= 1'b0;
      mmu_fault <= 1'b0;
      creq      <= 1'b0;
    end
    else
    begin
      mmu_fault <= 1'b0;                 // one cycle pulse
      case (state)
        idle:
        begin
          if (accept)
            state <= lookup;
        end
        lookup:
        begin
          cpu_busy <= 1'b1;
          if (cyc_tlb)
            state <= respond;            // entry written this edge
          else if (fault)
            state <= translate_fault;
          else if (cyc_we || cyc_inhibit || !hit)
            state <= mem_wait;
          else
            state <= respond;
        end
        translate_fault:
        begin
          mmu_fault <= 1'b1;
          cpu_busy  <= 1'b0;
          state     <= idle;
        end
        mem_wait:
        begin
          if (!creq)
            creq <= 1'b1;                // one edge after lookup
          else if (cack)
          begin
            creq     <= 1'b0;
            cpu_busy <= 1'b0;
            state    <= idle;
          end
        end
        respond:
        begin
          cpu_busy <= 1'b0;
          state    <= idle;
        end
        default:
          state <= idle;
      endcase
    end
  end

  // --------------------------------------------------
  // cycle registers and read data
  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      cyc_addr    <= cpu_addr;
      cyc_wdata   <= cpu_wdata;
      cyc_we      <= cpu_we && !tlb_we;
      cyc_tlb     <= tlb_we;
      cyc_vmem    <= vmem_en;
      cyc_inhibit <= cache_inhibit;
    end
    if ((state == respond) && !cyc_tlb)
      cpu_rdata <= rd_data;              // read hit
    else if ((state == mem_wait) && creq && cack && !cyc_we)
      cpu_rdata <= crdata;               // miss or inhibited read
  end

endmodule

// ==== rtl/mem_arbiter.sv ====
/*
 * Round-robin arbiter for the single memory port.
 * The cache controller and the DMA master are peers. A grant is taken in
 * an idle cycle, the request goes out on the next edge and is held until
 * mem_ack, which is steered back to the owner. A DMA write also
 * invalidates the cache line at its index.
 */
`timescale 1ns/100ps
`include "snowball_defines.svh"

module mem_arbiter
(
  input  logic                        CPU_CLK,
  input  logic                        RST,
  input  logic                        creq,
  input  snowball_pkg::mem_op_e       cop,
  input  logic [`SNOWBALL_ADDR_W-1:0] caddr,
  input  logic [`SNOWBALL_DATA_W-1:0] cwdata,
  output logic                        cack,
  output logic [`SNOWBALL_DATA_W-1:0] crdata,
  input  logic                        dma_req,
  input  logic                        dma_we,
  input  logic [`SNOWBALL_ADDR_W-1:0] dma_addr,
  input  logic [`SNOWBALL_DATA_W-1:0] dma_wdata,
  output logic                        dma_ack,
  output logic [`SNOWBALL_DATA_W-1:0] dma_rdata,
  output logic                        mem_req,
  output logic                        mem_we,
  output logic [`SNOWBALL_ADDR_W-1:0] mem_addr,
  output logic [`SNOWBALL_DATA_W-1:0] mem_wdata,
  input  logic                        mem_ack,
  input  logic [`SNOWBALL_DATA_W-1:0] mem_rdata,
  output logic                        inval,
  output logic [`SNOWBALL_IDX_W-1:0]  inval_idx
);

  import snowball_pkg::*;

  mem_op_e req_op;
  logic    grant;
  logic    own_dma;                      // owner of the current grant
  logic    prio_dma;                     // dma wins the next tie
  logic    pick_dma;
  logic    done;

  assign pick_dma = dma_req && (!creq || prio_dma);
  assign done     = grant && mem_req && mem_ack;

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      grant    <= 1'b0;
      own_dma  <= 1'b0;
      prio_dma <= 1'b0;
      mem_req  <= 1'b0;
    end
    else if (!grant)
    begin
      if (creq || dma_req)
      begin
        grant   <= 1'b1;
        own_dma <= pick_dma;
      end
    end
    else if (!mem_req)
      mem_req <= 1'b1;
    else if (mem_ack)
    begin
      mem_req  <= 1'b0;
      grant    <= 1'b0;
      prio_dma <= !own_dma;              // other master goes first next
    end
  end

  // request payload, latched as mem_req rises
  always_ff @(posedge CPU_CLK)
  begin
    if (grant && !mem_req)
    begin
      req_op    <= own_dma ? (dma_we ? op_write : op_read) : cop;
      mem_addr  <= own_dma ? dma_addr : caddr;
      mem_wdata <= own_dma ? dma_wdata : cwdata;
    end
  end

  assign mem_we    = (req_op == op_write);
  assign cack      = done && !own_dma;
  assign dma_ack   = done && own_dma;
  assign crdata    = mem_rdata;
  assign dma_rdata = mem_rdata;

  // snoop on dma writes
  assign inval     = dma_ack && mem_we;
  assign inval_idx = mem_addr[`SNOWBALL_IDX_W-1:0];

endmodule

// ==== rtl/snowball_top.sv ====
/*
 * Top level of the memory subsystem: cache controller, cache and TLB
 * arrays, and the memory port arbiter shared with the DMA master.
 */
`timescale 1ns/100ps
`include "snowball_defines.svh"

module snowball_top
(
  input  logic                        CPU_CLK,
  input  logic                        RST,
  // cpu port
  input  logic                        cpu_en,
  input  logic                        cpu_we,
  input  logic                        tlb_we,
  input  logic [`SNOWBALL_ADDR_W-1:0] cpu_addr,
  input  logic [`SNOWBALL_DATA_W-1:0] cpu_wdata,
  input  logic                        vmem_en,
  input  logic                        cache_inhibit,
  output logic [`SNOWBALL_DATA_W-1:0] cpu_rdata,
  output logic                        cpu_busy,
  output logic                        mmu_fault,
  // memory port
  output logic                        mem_req,
  output logic                        mem_we,
  output logic [`SNOWBALL_ADDR_W-1:0] mem_addr,
  output logic [`SNOWBALL_DATA_W-1:0] mem_wdata,
  input  logic                        mem_ack,
  input  logic [`SNOWBALL_DATA_W-1:0] mem_rdata,
  // dma port
  input  logic                        dma_req,
  input  logic                        dma_we,
  input  logic [`SNOWBALL_ADDR_W-1:0] dma_addr,
  input  logic [`SNOWBALL_DATA_W-1:0] dma_wdata,
  output logic                        dma_ack,
  output logic [`SNOWBALL_DATA_W-1:0] dma_rdata
);

  import snowball_pkg::*;

  // --------------------------------------------------
  // internal wiring
  logic                        rd_en;
  logic [`SNOWBALL_IDX_W-1:0]  rd_idx, tlb_rd_idx;
  logic [`SNOWBALL_TAG_W-1:0]  rd_tag;
  logic [`SNOWBALL_DATA_W-1:0] rd_data;
  logic                        rd_valid;
  logic [`SNOWBALL_PAGE_W-1:0] ppage, tlb_chk_vtag;
  logic                        fault, tlb_vmem;
  logic                        arr_wr_en, tlb_wr_en;
  logic [`SNOWBALL_IDX_W-1:0]  arr_wr_idx, tlb_wr_idx;
  logic [`SNOWBALL_TAG_W-1:0]  arr_wr_tag;
  logic [`SNOWBALL_DATA_W-1:0] arr_wr_data;
  logic [`SNOWBALL_PAGE_W-1:0] tlb_wr_ppage, tlb_wr_vtag;
  logic                        creq, cack;
  mem_op_e                     cop;
  logic [`SNOWBALL_ADDR_W-1:0] caddr;
  logic [`SNOWBALL_DATA_W-1:0] cwdata, crdata;
  logic                        inval;
  logic [`SNOWBALL_IDX_W-1:0]  inval_idx;

  cache_ctrl i_cache_ctrl
  (
    .CPU_CLK(CPU_CLK), .RST(RST),
    .cpu_en(cpu_en), .cpu_we(cpu_we), .tlb_we(tlb_we),
    .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
    .vmem_en(vmem_en), .cache_inhibit(cache_inhibit),
    .cpu_rdata(cpu_rdata), .cpu_busy(cpu_busy), .mmu_fault(mmu_fault),
    .rd_en(rd_en), .rd_idx(rd_idx), .tlb_rd_idx(tlb_rd_idx),
    .rd_tag(rd_tag), .rd_data(rd_data), .rd_valid(rd_valid),
    .ppage(ppage), .fault(fault),
    .tlb_chk_vtag(tlb_chk_vtag), .tlb_vmem(tlb_vmem),
    .arr_wr_en(arr_wr_en), .arr_wr_idx(arr_wr_idx),
    .arr_wr_tag(arr_wr_tag), .arr_wr_data(arr_wr_data),
    .tlb_wr_en(tlb_wr_en), .tlb_wr_idx(tlb_wr_idx),
    .tlb_wr_ppage(tlb_wr_ppage), .tlb_wr_vtag(tlb_wr_vtag),
    .creq(creq), .cop(cop), .caddr(caddr), .cwdata(cwdata),
    .cack(cack), .crdata(crdata)
  );

  cache_array i_cache_array
  (
    .CPU_CLK(CPU_CLK), .RST(RST),
    .rd_idx(rd_idx), .rd_en(rd_en),
    .wr_en(arr_wr_en), .wr_idx(arr_wr_idx),
    .wr_tag(arr_wr_tag), .wr_data(arr_wr_data),
    .inval(inval), .inval_idx(inval_idx),
    .rd_tag(rd_tag), .rd_data(rd_data), .rd_valid(rd_valid)
  );

  tlb_array i_tlb_array
  (
    .CPU_CLK(CPU_CLK), .RST(RST),
    .rd_idx(tlb_rd_idx), .rd_en(rd_en),
    .wr_en(tlb_wr_en), .wr_idx(tlb_wr_idx),
    .wr_ppage(tlb_wr_ppage), .wr_vtag(tlb_wr_vtag),
    .chk_vtag(tlb_chk_vtag), .vmem(tlb_vmem),
    .ppage(ppage), .fault(fault)
  );

  mem_arbiter i_mem_arbiter
  (
    .CPU_CLK(CPU_CLK), .RST(RST),
    .creq(creq), .cop(cop), .caddr(caddr), .cwdata(cwdata),
    .cack(cack), .crdata(crdata),
    .dma_req(dma_req), .dma_we(dma_we),
    .dma_addr(dma_addr), .dma_wdata(dma_wdata),
    .dma_ack(dma_ack), .dma_rdata(dma_rdata),
    .mem_req(mem_req), .mem_we(mem_we),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_ack(mem_ack), .mem_rdata(mem_rdata),
    .inval(inval), .inval_idx(inval_idx)
  );

endmodule

// ==== test/snowball_checker.sv ====
/*
 * Concurrent checks on the memory subsystem, bound into snowball_top.
 * Covers the memory request hold, acknowledge steering to exactly one
 * requester, fault isolation from memory, and the two-edge timing of a
 * cache hit.
 */
`timescale 1ns/100ps
`include "snowball_defines.svh"

module snowball_checker
(
  input logic                        CPU_CLK,
  input logic                        RST,
  input logic                        cpu_en,
  input logic                        tlb_we,
  input logic                        cpu_busy,
  input logic                        mmu_fault,
  input logic                        mem_req,
  input logic                        mem_ack,
  input logic                        mem_we,
  input logic [`SNOWBALL_ADDR_W-1:0] mem_addr,
  input logic [`SNOWBALL_DATA_W-1:0] mem_wdata,
  input logic                        creq,
  input logic                        cack,
  input logic                        dma_req,
  input logic                        dma_ack
);

  int       fail_cnt = 0;                // failed assertions so far
  logic     accept;
  logic     acc_q;                       // controller is in its lookup cycle
  logic [2:0] since_acc;
  logic     mem_since;

  // busy is low only in idle and in the cycle right after acceptance
  assign accept = (cpu_en || tlb_we) && !cpu_busy && !acc_q;

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      acc_q     <= 1'b0;
      since_acc <= '0;
      mem_since <= 1'b0;
    end
    else
    begin
      acc_q <= accept;
      if (accept)
      begin
        since_acc <= '0;
        mem_since <= 1'b0;
      end
      else
      begin
        if (since_acc != 3'd7)
          since_acc <= since_acc + 3'd1; // saturating edge count
        if (mem_req)
          mem_since <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  hold_req: assert property (@(posedge CPU_CLK) disable iff (!RST)
    mem_req && !mem_ack |=> mem_req && $stable(mem_addr) && $stable(mem_wdata)
                            && $stable(mem_we))
    else
    begin
      $error("memory request dropped or changed before mem_ack");
      fail_cnt = fail_cnt + 1;
    end

  one_ack: assert property (@(posedge CPU_CLK) disable iff (!RST)
    mem_req && mem_ack |-> (cack && creq && !dma_ack) || (dma_ack && dma_req && !cack))
    else
    begin
      $error("memory acknowledge not returned to exactly one requesting master");
      fail_cnt = fail_cnt + 1;
    end

  fault_quiet: assert property (@(posedge CPU_CLK) disable iff (!RST)
    ($past(mmu_fault) || $past(mmu_fault, 2)) |-> !mem_req)
    else
    begin
      $error("memory request within two cycles of an MMU fault");
      fail_cnt = fail_cnt + 1;
    end

  hit_time: assert property (@(posedge CPU_CLK) disable iff (!RST)
    $fell(cpu_busy) && !mem_since |-> since_acc == 3'd2)
    else
    begin
      $error("access without memory did not finish two edges after acceptance");
      fail_cnt = fail_cnt + 1;
    end

endmodule

// ==== test/snowball_tb.sv ====
/*
 * Testbench for the snowball memory subsystem.
 * Drives the CPU and DMA ports, models memory with a random acknowledge
 * delay, and checks each response against the memory and cache rules.
 * Prints one line per test, a closing count and the overall result.
 */
`timescale 1ns/100ps
`include "snowball_defines.svh"

module snowball_tb;

  parameter int MEM_MAX_LAT = 4;                 // longest mem_req to mem_ack in cycles

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_REQUESTS = 15;              // cpu accesses plus dma transfers

  logic                        CPU_CLK;
  logic                        RST;
  logic                        cpu_en;
  logic                        cpu_we;
  logic                        tlb_we;
  logic [`SNOWBALL_ADDR_W-1:0] cpu_addr;
  logic [`SNOWBALL_DATA_W-1:0] cpu_wdata;
  logic                        vmem_en;
  logic                        cache_inhibit;
  logic [`SNOWBALL_DATA_W-1:0] cpu_rdata;
  logic                        cpu_busy;
  logic                        mmu_fault;
  logic                        mem_req;
  logic                        mem_we;
  logic [`SNOWBALL_ADDR_W-1:0] mem_addr;
  logic [`SNOWBALL_DATA_W-1:0] mem_wdata;
  logic                        mem_ack;
  logic [`SNOWBALL_DATA_W-1:0] mem_rdata;
  logic                        dma_req;
  logic                        dma_we;
  logic [`SNOWBALL_ADDR_W-1:0] dma_addr;
  logic [`SNOWBALL_DATA_W-1:0] dma_wdata;
  logic                        dma_ack;
  logic [`SNOWBALL_DATA_W-1:0] dma_rdata;

  logic [31:0] mem_store [logic [31:0]];         // written memory words
  logic [31:0] lcg_state = 32'd58117;
  int          test_errs = 0;
  int          total_errs = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  // last cpu access
  logic [31:0] res_rdata;
  logic [31:0] res_addr;
  logic        res_we;
  logic        res_mem;
  logic        res_fault;
  int          res_edges;

  snowball_top i_snowball_top (.*);

  bind snowball_top snowball_checker i_snowball_checker
  (
    .CPU_CLK(CPU_CLK), .RST(RST), .cpu_en(cpu_en), .tlb_we(tlb_we),
    .cpu_busy(cpu_busy), .mmu_fault(mmu_fault),
    .mem_req(mem_req), .mem_ack(mem_ack), .mem_we(mem_we),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .creq(creq), .cack(cack), .dma_req(dma_req), .dma_ack(dma_ack)
  );

  initial CPU_CLK = 1'b0;
  always #(CLK_PERIOD / 2) CPU_CLK = ~CPU_CLK;

  // --------------------------------------------------
  // helpers
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ 32'h5A5A_0000;                 // never written
  endfunction

  function automatic logic [31:0] model_word(input logic [31:0] addr);
    if (mem_store.exists(addr))
      return mem_store[addr];
    return fill_word(addr);
  endfunction

  task automatic check_that(input logic ok, input string what);
    assert (ok)
    else
    begin
      $display("FAILED at %0t ns: %s", $time, what);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0)
      $display("test %s: passed", name);
    else
      $display("test %s: %0d errors", name, test_errs);
    tests_run++;
    if (test_errs != 0)
      tests_failed++;
    total_errs += test_errs;
    test_errs = 0;
  endtask

  // issues one cpu request and returns once cpu_busy is low again
  task automatic cpu_access(input logic we, input logic tlb, input logic [31:0] addr,
                            input logic [31:0] wdata);
    @(posedge CPU_CLK);
    #1;
    cpu_en    = !tlb;
    tlb_we    = tlb;
    cpu_we    = we;
    cpu_addr  = addr;
    cpu_wdata = wdata;
    @(posedge CPU_CLK);                          // accepted here
    #1;
    cpu_en    = 1'b0;
    tlb_we    = 1'b0;
    cpu_we    = 1'b0;
    res_mem   = 1'b0;
    res_fault = 1'b0;
    res_edges = 0;
    do
    begin
      @(posedge CPU_CLK);
      #1;
      res_edges++;
      if (mem_req && !res_mem)
      begin
        res_addr = mem_addr;
        res_we   = mem_we;
      end
      res_mem   = res_mem | mem_req;
      res_fault = res_fault | mmu_fault;
    end
    while (cpu_busy);
    res_rdata = cpu_rdata;
  endtask

  task automatic dma_transfer(input logic we, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge CPU_CLK);
    #1;
    dma_req   = 1'b1;
    dma_we    = we;
    dma_addr  = addr;
    dma_wdata = wdata;
    do
    begin
      @(posedge CPU_CLK);
      #3;                                        // dma_ack follows mem_ack
    end
    while (!dma_ack);
    rdata = dma_rdata;
    @(posedge CPU_CLK);
    #1;
    dma_req = 1'b0;
    dma_we  = 1'b0;
  endtask

  // --------------------------------------------------
  // memory model
  initial
  begin : memory_model
    logic [31:0] r;
    int          lat;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    forever
    begin
      @(posedge CPU_CLK);
      #1;
      if (mem_req)
      begin
        r   = lcg_next();
        lat = 1 + int'(r[23:8]) % MEM_MAX_LAT;
        repeat (lat - 1)
        begin
          @(posedge CPU_CLK);
          #1;
        end
        if (mem_we)
          mem_store[mem_addr] = mem_wdata;
        mem_rdata = model_word(mem_addr);
        mem_ack   = 1'b1;
        @(posedge CPU_CLK);
        #1;
        mem_ack   = 1'b0;
      end
    end
  end

  initial
  begin : watchdog
    #((RESET_CYCLES + 40 * NUM_REQUESTS) * CLK_PERIOD);
    $display("watchdog expired, the tests did not finish in time");
    $display("** FAIL **");
    $finish;
  end

  // --------------------------------------------------
  // stimulus
  initial
  begin : stimulus
    logic [31:0] dma_data;
    logic [31:0] inh_addr;
    RST           = 1'b0;
    cpu_en        = 1'b0;
    cpu_we        = 1'b0;
    tlb_we        = 1'b0;
    cpu_addr      = '0;
    cpu_wdata     = '0;
    vmem_en       = 1'b0;
    cache_inhibit = 1'b0;
    dma_req       = 1'b0;
    dma_we        = 1'b0;
    dma_addr      = '0;
    dma_wdata     = '0;
    repeat (RESET_CYCLES) @(posedge CPU_CLK);
    #1;
    RST = 1'b1;

    check_that(!cpu_busy && !mem_req && !mmu_fault && !dma_ack, "outputs not idle after reset");
    cpu_access(1'b0, 1'b0, 32'h0000_1234, '0);
    check_that(res_mem, "first read after reset made no memory request");
    check_that(res_rdata == fill_word(32'h0000_1234),
               $sformatf("first read returned %h", res_rdata));
    finish_test("reset");

    cpu_access(1'b0, 1'b0, 32'h0000_2340, '0);
    check_that(res_mem && res_rdata == fill_word(32'h0000_2340),
               $sformatf("read miss returned %h, memory used %0b", res_rdata, res_mem));
    cpu_access(1'b0, 1'b0, 32'h0000_2340, '0);
    check_that(res_rdata == fill_word(32'h0000_2340), $sformatf("hit returned %h", res_rdata));
    check_that(res_edges == 2 && !res_mem,
               $sformatf("hit took %0d edges, memory used %0b", res_edges, res_mem));
    finish_test("miss_hit");

    cpu_access(1'b1, 1'b0, 32'h0000_3450, 32'hCAFE_0001);
    check_that(res_mem && res_we && res_addr == 32'h0000_3450,
               $sformatf("write went to %h with we %0b", res_addr, res_we));
    check_that(model_word(32'h0000_3450) == 32'hCAFE_0001, "write data did not reach memory");
    cpu_access(1'b0, 1'b0, 32'h0000_3450, '0);
    check_that(!res_mem && res_rdata == 32'hCAFE_0001,
               $sformatf("read after write returned %h, memory used %0b", res_rdata, res_mem));
    finish_test("write_through");

    vmem_en = 1'b1;
    cpu_access(1'b0, 1'b1, 32'h0000_1200, 32'h00AB_0040);   // vtag 0040 maps to page 00ab
    check_that(res_edges == 2 && !res_mem,
               $sformatf("TLB write took %0d edges, memory used %0b", res_edges, res_mem));
    cpu_access(1'b0, 1'b0, 32'h0040_1260, '0);
    check_that(res_mem && res_addr == 32'h00AB_1260,
               $sformatf("translated read went to %h", res_addr));
    check_that(res_rdata == fill_word(32'h00AB_1260),
               $sformatf("translated read returned %h", res_rdata));
    cpu_access(1'b0, 1'b0, 32'h0041_1264, '0);               // tag mismatch
    check_that(res_fault && !res_mem && res_edges == 2,
               $sformatf("fault %0b, memory used %0b, %0d edges", res_fault, res_mem, res_edges));
    vmem_en = 1'b0;
    finish_test("translation");

    cache_inhibit = 1'b1;
    for (int i = 0; i < 3; i++)
    begin
      inh_addr = (i == 2) ? 32'h0000_2340 : 32'h0000_5678;  // last one is cached
      cpu_access(1'b0, 1'b0, inh_addr, '0);
      check_that(res_mem && res_addr == inh_addr && res_rdata == fill_word(inh_addr),
                 $sformatf("inhibited read %0d returned %h from %h", i, res_rdata, res_addr));
    end
    cache_inhibit = 1'b0;
    finish_test("inhibit");

    fork
      dma_transfer(1'b0, 32'h0000_6000, '0, dma_data);
      cpu_access(1'b0, 1'b0, 32'h0000_7070, '0);
    join
    check_that(dma_data == fill_word(32'h0000_6000),
               $sformatf("DMA read returned %h", dma_data));
    check_that(res_rdata == fill_word(32'h0000_7070),
               $sformatf("CPU read beside DMA returned %h", res_rdata));
    dma_transfer(1'b1, 32'h0000_2340, 32'hD0D0_0002, dma_data);
    cpu_access(1'b0, 1'b0, 32'h0000_2340, '0);
    check_that(res_mem && res_rdata == 32'hD0D0_0002,
               $sformatf("read after DMA write returned %h, memory used %0b", res_rdata, res_mem));
    finish_test("dma_sharing");

    $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, total_errs, i_snowball_top.i_snowball_checker.fail_cnt);
    if (total_errs == 0 && i_snowball_top.i_snowball_checker.fail_cnt == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+include
rtl/snowball_pkg.sv
rtl/cache_array.sv
rtl/tlb_array.sv
rtl/cache_ctrl.sv
rtl/mem_arbiter.sv
rtl/snowball_top.sv
test/snowball_checker.sv
test/snowball_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the snowball testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module snowball_tb -f sources.f -o snowball_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/snowball_sim +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qxF '** PASS **' && echo "result: passed" || { echo "result: failed"; exit 1; }
